// File: core_mon_pkg.sv
/* Core monitor shared definitions */

`default_nettype none

package core_mon_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Address and PC width of the core
  parameter int unsigned ADDR_W     = 32;
  // Store data width on the data bus
  parameter int unsigned DATA_W     = 32;
  // One byte enable per byte of write data
  parameter int unsigned BE_W       = 4;
  // One checksum bit per group of request fields
  parameter int unsigned ACHK_W     = 12;
  parameter int unsigned EXC_CODE_W = 5;
  // Number of exception causes whose mepc is tracked
  parameter int unsigned NUM_CAUSES = 6;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Exception codes as written to mcause
  // Instruction bus fault is a custom code
  typedef enum logic [EXC_CODE_W-1:0] {
    INSTR_FAULT     = 5'd1,
    ILLEGAL_INSN    = 5'd2,
    BREAKPOINT      = 5'd3,
    ECALL_MMODE     = 5'd8,
    ECALL_UMODE     = 5'd11,
    INSTR_BUS_FAULT = 5'd24
  } exc_code_e;

  // Slot of each tracked cause in the mepc error vector
  typedef enum logic [2:0] {
    IDX_ILLEGAL_INSN    = 3'd0,
    IDX_ECALL_MMODE     = 3'd1,
    IDX_ECALL_UMODE     = 3'd2,
    IDX_BREAKPOINT      = 3'd3,
    IDX_INSTR_BUS_FAULT = 3'd4,
    IDX_INSTR_FAULT     = 3'd5
  } cause_idx_e;

  // Single-step tracking states
  typedef enum logic [1:0] {
    S_RUN      = 2'd0,
    S_STEP     = 2'd1,
    S_IRQ_WAIT = 2'd2,
    S_DEBUG    = 2'd3
  } step_state_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // OBI address phase as seen on either bus
  // On the instruction bus we, be and wdata stay at zero
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        memtype;
    logic [2:0]        prot;
    logic              dbg;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // A retirement that trapped, with the resolved cause
  typedef struct packed {
    logic                  valid;
    logic [EXC_CODE_W-1:0] code;
    logic [ADDR_W-1:0]     pc;
  } trap_evt_t;

  // Exception write of mcause and mepc
  typedef struct packed {
    logic                  valid;
    logic [EXC_CODE_W-1:0] code;
    logic [ADDR_W-1:0]     mepc;
  } csr_save_t;

  // Sticky error flags of the monitor
  typedef struct packed {
    logic                  instr_achk;
    logic                  data_achk;
    logic                  instr_par;
    logic                  data_par;
    logic                  step_multi;
    logic                  step_irq;
    logic [NUM_CAUSES-1:0] mepc;
  } mon_err_t;

endpackage

`default_nettype wire

// File: bus_integrity_check.sv
/* Bus checksum and parity check */

`timescale 1ns/1ps
`default_nettype none

module bus_integrity_check import core_mon_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_ni,
  input  wire obi_req_t          instr_req_i,
  input  wire obi_req_t          data_req_i,
  input  wire logic              instr_reqpar_i,
  input  wire logic              data_reqpar_i,
  input  wire logic [ACHK_W-1:0] instr_achk_i,
  input  wire logic [ACHK_W-1:0] data_achk_i,
  output logic [1:0]             achk_err_o,
  output logic [1:0]             par_err_o
);

  ////////////////////////////////////////////////////////////
  // Expected checksum
  ////////////////////////////////////////////////////////////

  // Each bit is the odd parity of one field group, high group first
  // The instruction bus has no be/we, so that group uses a fixed pattern
  function automatic logic [ACHK_W-1:0] calc_achk(obi_req_t r, logic is_instr);
    logic [BE_W:0] be_we;
    be_we = is_instr ? {{BE_W{1'b1}}, 1'b0} : {r.be, r.we};
    return {
      ~^r.wdata[31:24],
      ~^r.wdata[23:16],
      ~^r.wdata[15:8],
      ~^r.wdata[7:0],
      ~^6'b0,
      ~^r.dbg,
      ~^be_we,
      ~^{r.prot, r.memtype},
      ~^r.addr[31:24],
      ~^r.addr[23:16],
      ~^r.addr[15:8],
      ~^r.addr[7:0]
    };
  endfunction

  logic [ACHK_W-1:0] instr_achk_exp;
  logic [ACHK_W-1:0] data_achk_exp;

  assign instr_achk_exp = calc_achk(instr_req_i, 1'b1);
  assign data_achk_exp  = calc_achk(data_req_i, 1'b0);

  ////////////////////////////////////////////////////////////
  // Mismatch detection
  ////////////////////////////////////////////////////////////

  // Bit 1 is the instruction bus, bit 0 the data bus
  logic [1:0] achk_mis;
  logic [1:0] par_mis;

  assign achk_mis[1] = (instr_achk_i != instr_achk_exp);
  assign achk_mis[0] = (data_achk_i != data_achk_exp);

  // reqpar must always be the inverse of req
  assign par_mis[1] = (instr_reqpar_i == instr_req_i.req);
  assign par_mis[0] = (data_reqpar_i == data_req_i.req);

  ////////////////////////////////////////////////////////////
  // Sticky flags
  ////////////////////////////////////////////////////////////

  logic [1:0] achk_err_q;
  logic [1:0] par_err_q;

  // Checked every cycle, a flag once set stays until reset
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      achk_err_q <= 2'b00;
      par_err_q  <= 2'b00;
    end else begin
      achk_err_q <= achk_err_q | achk_mis;
      par_err_q  <= par_err_q | par_mis;
    end
  end

  assign achk_err_o = achk_err_q;
  assign par_err_o  = par_err_q;

endmodule

`default_nettype wire

// File: step_fsm.sv
/* Single-step window tracker */

`timescale 1ns/1ps
`default_nettype none

module step_fsm import core_mon_pkg::*; #(
  parameter int unsigned CNT_W = 2
) (
  input  wire logic             clk,
  input  wire logic             rst_ni,
  input  wire logic             step_i,
  input  wire logic             debug_mode_i,
  input  wire logic             wb_valid_i,
  input  wire logic             irq_ack_i,
  input  wire logic [CNT_W-1:0] count_i,
  output logic                  cnt_clear_o,
  output logic                  cnt_en_o,
  output logic                  step_multi_o,
  output logic                  step_irq_o
);

  step_state_e state_q, state_d;
  logic        step_multi_q;
  logic        step_irq_q;
  logic        multi_hit;
  logic        irq_hit;

  ////////////////////////////////////////////////////////////
  // Next state and counter control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cnt_clear_o = 1'b0;
    cnt_en_o    = 1'b0;
    multi_hit   = 1'b0;
    irq_hit     = 1'b0;
    // Debug entry wins in every state and retirements in debug are ignored
    if (debug_mode_i) begin
      state_d = S_DEBUG;
    end else begin
      case (state_q)
        S_RUN: begin
          // A new step window starts with an empty count
          if (step_i) begin
            state_d     = S_STEP;
            cnt_clear_o = 1'b1;
          end
        end
        S_STEP: begin
          if (wb_valid_i) begin
            cnt_en_o  = 1'b1;
            // Something already retired in this window
            multi_hit = (count_i != '0);
          end
          if (irq_ack_i) begin
            state_d = S_IRQ_WAIT;
          end
        end
        S_IRQ_WAIT: begin
          // After an interrupt nothing may retire before the debug halt
          irq_hit = wb_valid_i;
        end
        default: begin
          // S_DEBUG, left once the core resumes
          state_d = S_RUN;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // State and sticky error registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= S_RUN;
      step_multi_q <= 1'b0;
      step_irq_q   <= 1'b0;
    end else begin
      state_q      <= state_d;
      step_multi_q <= step_multi_q | multi_hit;
      step_irq_q   <= step_irq_q | irq_hit;
    end
  end

  assign step_multi_o = step_multi_q;
  assign step_irq_o   = step_irq_q;

endmodule

`default_nettype wire

// File: retire_counter.sv
/* Saturating retirement counter */

`timescale 1ns/1ps
`default_nettype none

module retire_counter #(
  parameter int unsigned CNT_W = 2
) (
  input  wire logic             clk,
  input  wire logic             rst_ni,
  input  wire logic             clear_i,
  input  wire logic             en_i,
  output logic      [CNT_W-1:0] count_o
);

  logic [CNT_W-1:0] count_q;
  logic             at_max;

  // Stop at all ones so a long window never wraps back to zero
  assign at_max = &count_q;

  // Clear has priority over counting
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (en_i && !at_max) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

// File: trap_pc_tracker.sv
/* Trap PC against mepc tracker */

`timescale 1ns/1ps
`default_nettype none

module trap_pc_tracker import core_mon_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_ni,
  input  wire trap_evt_t             trap_i,
  input  wire csr_save_t             save_i,
  output logic      [NUM_CAUSES-1:0] mepc_err_o
);

  ////////////////////////////////////////////////////////////
  // Cause decode
  ////////////////////////////////////////////////////////////

  // One-hot slot of a tracked code, all zero for other codes
  function automatic logic [NUM_CAUSES-1:0] cause_sel(logic [EXC_CODE_W-1:0] code);
    logic [NUM_CAUSES-1:0] sel;
    sel = '0;
    case (code)
      ILLEGAL_INSN:    sel[IDX_ILLEGAL_INSN]    = 1'b1;
      ECALL_MMODE:     sel[IDX_ECALL_MMODE]     = 1'b1;
      ECALL_UMODE:     sel[IDX_ECALL_UMODE]     = 1'b1;
      BREAKPOINT:      sel[IDX_BREAKPOINT]      = 1'b1;
      INSTR_BUS_FAULT: sel[IDX_INSTR_BUS_FAULT] = 1'b1;
      INSTR_FAULT:     sel[IDX_INSTR_FAULT]     = 1'b1;
      default:         sel = '0;
    endcase
    return sel;
  endfunction

  logic [NUM_CAUSES-1:0] trap_hit;
  logic [NUM_CAUSES-1:0] save_hit;

  assign trap_hit = trap_i.valid ? cause_sel(trap_i.code) : '0;
  assign save_hit = save_i.valid ? cause_sel(save_i.code) : '0;

  ////////////////////////////////////////////////////////////
  // First occurrence per cause
  ////////////////////////////////////////////////////////////

  logic [NUM_CAUSES-1:0] exp_found_q;
  logic [NUM_CAUSES-1:0] act_found_q;
  logic [ADDR_W-1:0]     exp_pc_q [NUM_CAUSES];
  logic [ADDR_W-1:0]     act_pc_q [NUM_CAUSES];
  logic [NUM_CAUSES-1:0] exp_take;
  logic [NUM_CAUSES-1:0] act_take;

  // Only the first event of a cause is kept, later ones are dropped
  assign exp_take = trap_hit & ~exp_found_q;
  assign act_take = save_hit & ~act_found_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_found_q <= '0;
      act_found_q <= '0;
    end else begin
      exp_found_q <= exp_found_q | exp_take;
      act_found_q <= act_found_q | act_take;
    end
  end

  // Captured values are only looked at once the found flag is set
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_CAUSES; i++) begin
      if (exp_take[i]) begin
        exp_pc_q[i] <= trap_i.pc;
      end
      if (act_take[i]) begin
        act_pc_q[i] <= save_i.mepc;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////

  // Runs on the edge after both sides of a cause are recorded
  logic [NUM_CAUSES-1:0] mis;
  logic [NUM_CAUSES-1:0] mepc_err_q;

  always_comb begin
    for (int i = 0; i < NUM_CAUSES; i++) begin
      mis[i] = exp_found_q[i] && act_found_q[i] && (exp_pc_q[i] != act_pc_q[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_err_q <= '0;
    end else begin
      mepc_err_q <= mepc_err_q | mis;
    end
  end

  assign mepc_err_o = mepc_err_q;

endmodule

`default_nettype wire

// File: core_mon_top.sv
/* Core run-time monitor */

`timescale 1ns/1ps
`default_nettype none

module core_mon_top import core_mon_pkg::*; #(
  parameter int unsigned CNT_W = 2
) (
  input  wire logic              clk,
  input  wire logic              rst_ni,
  input  wire obi_req_t          instr_req_i,
  input  wire obi_req_t          data_req_i,
  input  wire logic              instr_reqpar_i,
  input  wire logic              data_reqpar_i,
  input  wire logic [ACHK_W-1:0] instr_achk_i,
  input  wire logic [ACHK_W-1:0] data_achk_i,
  input  wire trap_evt_t         trap_i,
  input  wire csr_save_t         save_i,
  input  wire logic              wb_valid_i,
  input  wire logic              irq_ack_i,
  input  wire logic              step_i,
  input  wire logic              debug_mode_i,
  output mon_err_t               err_o
);

  // Bus flags are ordered instruction bus high, data bus low
  logic [1:0]            achk_err;
  logic [1:0]            par_err;
  logic [NUM_CAUSES-1:0] mepc_err;
  logic                  step_multi;
  logic                  step_irq;
  logic                  cnt_clear;
  logic                  cnt_en;
  logic [CNT_W-1:0]      count;

  ////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////

  bus_integrity_check i_bus_check (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .data_req_i     (data_req_i),
    .instr_reqpar_i (instr_reqpar_i),
    .data_reqpar_i  (data_reqpar_i),
    .instr_achk_i   (instr_achk_i),
    .data_achk_i    (data_achk_i),
    .achk_err_o     (achk_err),
    .par_err_o      (par_err)
  );

  // The FSM owns the window, the counter only tallies retirements
  step_fsm #(
    .CNT_W (CNT_W)
  ) i_step_fsm (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .step_i       (step_i),
    .debug_mode_i (debug_mode_i),
    .wb_valid_i   (wb_valid_i),
    .irq_ack_i    (irq_ack_i),
    .count_i      (count),
    .cnt_clear_o  (cnt_clear),
    .cnt_en_o     (cnt_en),
    .step_multi_o (step_multi),
    .step_irq_o   (step_irq)
  );

  retire_counter #(
    .CNT_W (CNT_W)
  ) i_retire_counter (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .clear_i (cnt_clear),
    .en_i    (cnt_en),
    .count_o (count)
  );

  trap_pc_tracker i_trap_tracker (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .trap_i     (trap_i),
    .save_i     (save_i),
    .mepc_err_o (mepc_err)
  );

  ////////////////////////////////////////////////////////////
  // Error vector
  ////////////////////////////////////////////////////////////

  // Every unit already holds its flags sticky
  always_comb begin
    err_o.instr_achk = achk_err[1];
    err_o.data_achk  = achk_err[0];
    err_o.instr_par  = par_err[1];
    err_o.data_par   = par_err[0];
    err_o.step_multi = step_multi;
    err_o.step_irq   = step_irq;
    err_o.mepc       = mepc_err;
  end

endmodule

`default_nettype wire

// File: tb_core_mon.sv
/* Core monitor testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_core_mon import core_mon_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int CNT_W      = 2;
  localparam int CNT_MAX    = (1 << CNT_W) - 1;
  // Cycle budget of each phase with a rough allowance for the directed parts
  localparam int N_CLEAN    = 200;
  localparam int N_STEP_RND = 300;
  localparam int N_BUS      = 400;
  localparam int N_DIRECTED = 150;
  localparam int MARGIN     = 100;
  localparam int TIMEOUT_NS =
    (N_CLEAN + N_STEP_RND + N_BUS + N_DIRECTED + MARGIN) * CLK_PERIOD;

  logic              clk;
  logic              rst_ni;
  obi_req_t          instr_req_i;
  obi_req_t          data_req_i;
  logic              instr_reqpar_i;
  logic              data_reqpar_i;
  logic [ACHK_W-1:0] instr_achk_i;
  logic [ACHK_W-1:0] data_achk_i;
  trap_evt_t         trap_i;
  csr_save_t         save_i;
  logic              wb_valid_i;
  logic              irq_ack_i;
  logic              step_i;
  logic              debug_mode_i;
  mon_err_t          err_o;

  integer seed = 42343;
  bit     inject_faults = 1'b0;
  int     bad_idx;

  core_mon_top #(
    .CNT_W (CNT_W)
  ) i_dut (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .data_req_i     (data_req_i),
    .instr_reqpar_i (instr_reqpar_i),
    .data_reqpar_i  (data_reqpar_i),
    .instr_achk_i   (instr_achk_i),
    .data_achk_i    (data_achk_i),
    .trap_i         (trap_i),
    .save_i         (save_i),
    .wb_valid_i     (wb_valid_i),
    .irq_ack_i      (irq_ack_i),
    .step_i         (step_i),
    .debug_mode_i   (debug_mode_i),
    .err_o          (err_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Inverted parity per group with addr bytes in bits 3..0 and wdata bytes in 11..8
  function automatic logic [ACHK_W-1:0] model_achk(obi_req_t r, bit is_instr);
    logic [ACHK_W-1:0] c;
    logic [4:0]        be_we;
    be_we = is_instr ? 5'b11110 : {r.be, r.we};
    for (int b = 0; b < 4; b++) begin
      c[b]     = ~^r.addr[8*b +: 8];
      c[8 + b] = ~^r.wdata[8*b +: 8];
    end
    c[4] = ~^{r.prot, r.memtype};
    c[5] = ~^be_we;
    c[6] = ~r.dbg;
    // Padding group holds only zeros
    c[7] = 1'b1;
    return c;
  endfunction

  // Tracked cause slot of a code or -1 when the code is not tracked
  function automatic int cause_of(logic [4:0] code);
    case (code)
      5'd2:    return 0;
      5'd8:    return 1;
      5'd11:   return 2;
      5'd3:    return 3;
      5'd24:   return 4;
      5'd1:    return 5;
      default: return -1;
    endcase
  endfunction

  function automatic logic [4:0] code_of(int idx);
    case (idx)
      0:       return 5'd2;
      1:       return 5'd8;
      2:       return 5'd11;
      3:       return 5'd3;
      4:       return 5'd24;
      default: return 5'd1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Model of the monitor
  ////////////////////////////////////////////////////////////

  mon_err_t    exp_err;
  step_state_e m_state;
  int          m_count;
  logic [5:0]  m_exp_found;
  logic [5:0]  m_act_found;
  logic [31:0] m_exp_pc [6];
  logic [31:0] m_act_pc [6];

  always @(posedge clk) begin : model_update
    int t_idx;
    int s_idx;
    if (!rst_ni) begin
      exp_err     = '0;
      m_state     = S_RUN;
      m_count     = 0;
      m_exp_found = '0;
      m_act_found = '0;
    end else begin
      if (instr_achk_i != model_achk(instr_req_i, 1'b1)) exp_err.instr_achk = 1'b1;
      if (data_achk_i != model_achk(data_req_i, 1'b0))   exp_err.data_achk  = 1'b1;
      if (instr_reqpar_i == instr_req_i.req)              exp_err.instr_par  = 1'b1;
      if (data_reqpar_i == data_req_i.req)                exp_err.data_par   = 1'b1;
      // Single-step window
      if (debug_mode_i) begin
        m_state = S_DEBUG;
      end else begin
        case (m_state)
          S_RUN: begin
            if (step_i) begin
              m_state = S_STEP;
              m_count = 0;
            end
          end
          S_STEP: begin
            if (wb_valid_i) begin
              if (m_count != 0) exp_err.step_multi = 1'b1;
              if (m_count < CNT_MAX) m_count++;
            end
            if (irq_ack_i) m_state = S_IRQ_WAIT;
          end
          S_IRQ_WAIT: begin
            if (wb_valid_i) exp_err.step_irq = 1'b1;
          end
          default: m_state = S_RUN;
        endcase
      end
      // Compare uses what was recorded before this edge
      for (int i = 0; i < 6; i++) begin
        if (m_exp_found[i] && m_act_found[i] && (m_exp_pc[i] != m_act_pc[i])) begin
          exp_err.mepc[i] = 1'b1;
        end
      end
      t_idx = cause_of(trap_i.code);
      s_idx = cause_of(save_i.code);
      if (trap_i.valid && t_idx >= 0 && !m_exp_found[t_idx]) begin
        m_exp_found[t_idx] = 1'b1;
        m_exp_pc[t_idx]    = trap_i.pc;
      end
      if (save_i.valid && s_idx >= 0 && !m_act_found[s_idx]) begin
        m_act_found[s_idx] = 1'b1;
        m_act_pc[s_idx]    = save_i.mepc;
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // The DUT and the model have both settled by the falling edge
  always @(negedge clk) begin
    if (rst_ni === 1'b1) check_value("err_o", err_o, exp_err);
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the stimulus did not finish within %0d ns", TIMEOUT_NS);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic obi_req_t rand_req(bit is_instr);
    obi_req_t    r;
    logic [31:0] rnd;
    r         = '0;
    rnd       = $random(seed);
    r.req     = rnd[0];
    r.memtype = rnd[7:6];
    r.prot    = rnd[10:8];
    r.dbg     = rnd[11];
    r.addr    = $random(seed);
    if (!is_instr) begin
      r.we    = rnd[1];
      r.be    = rnd[5:2];
      r.wdata = $random(seed);
    end
    return r;
  endfunction

  // Drives correct sidebands and flips one bit now and then when faults are on
  task automatic drive_bus();
    obi_req_t    ir;
    obi_req_t    dr;
    logic [31:0] pick;
    ir             = rand_req(1'b1);
    dr             = rand_req(1'b0);
    instr_req_i    = ir;
    data_req_i     = dr;
    instr_achk_i   = model_achk(ir, 1'b1);
    data_achk_i    = model_achk(dr, 1'b0);
    instr_reqpar_i = ~ir.req;
    data_reqpar_i  = ~dr.req;
    pick           = $random(seed);
    if (inject_faults && pick[3:0] == 4'd0) begin
      case (pick[5:4])
        2'd0:    instr_achk_i = instr_achk_i ^ (12'h001 << (pick[9:6] % 12));
        2'd1:    data_achk_i  = data_achk_i ^ (12'h001 << (pick[9:6] % 12));
        2'd2:    instr_reqpar_i = ~instr_reqpar_i;
        default: data_reqpar_i  = ~data_reqpar_i;
      endcase
    end
  endtask

  // Strobes drop back to zero in the next cycle unless the caller sets them again
  task automatic advance();
    @(posedge clk);
    #1;
    wb_valid_i = 1'b0;
    irq_ack_i  = 1'b0;
    trap_i     = '0;
    save_i     = '0;
    drive_bus();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_ni       = 1'b0;
    step_i       = 1'b0;
    debug_mode_i = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    check_value("err_o", err_o, '0);
  endtask

  // Opens a window, optionally takes an interrupt, retires, then halts in debug
  task automatic step_window(input int n_retire, input bit take_irq);
    advance();
    step_i = 1'b1;
    advance();
    step_i = 1'b0;
    if (take_irq) begin
      advance();
      irq_ack_i = 1'b1;
    end
    repeat (n_retire) begin
      advance();
      wb_valid_i = 1'b1;
    end
    advance();
    debug_mode_i = 1'b1;
    repeat (2) advance();
    debug_mode_i = 1'b0;
    advance();
  endtask

  // One trap and one save per cause where a fresh round may corrupt one mepc
  task automatic trap_round(input int bad, input bit fresh);
    logic [31:0] pc;
    logic [31:0] mepc;
    logic [31:0] rnd;
    for (int i = 0; i < 6; i++) begin
      pc   = $random(seed);
      mepc = (i == bad) ? pc ^ 32'h0000_0004 : pc;
      if (!fresh) mepc = $random(seed);
      rnd  = $random(seed);
      advance();
      trap_i = '{1'b1, code_of(i), pc};
      if (!rnd[0]) advance();
      save_i = '{1'b1, code_of(i), mepc};
      // An untracked code in between must be ignored
      if (rnd[1]) begin
        advance();
        trap_i = '{1'b1, 5'd7, $random(seed)};
        save_i = '{1'b1, 5'd7, $random(seed)};
      end
    end
    repeat (3) advance();
  endtask

  initial begin
    rst_ni         = 1'b0;
    instr_req_i    = '0;
    data_req_i     = '0;
    instr_reqpar_i = 1'b1;
    data_reqpar_i  = 1'b1;
    instr_achk_i   = model_achk(instr_req_i, 1'b1);
    data_achk_i    = model_achk(data_req_i, 1'b0);
    trap_i         = '0;
    save_i         = '0;
    wb_valid_i     = 1'b0;
    irq_ack_i      = 1'b0;
    step_i         = 1'b0;
    debug_mode_i   = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    check_value("err_o", err_o, '0);

    // Clean bus traffic keeps every flag low
    repeat (N_CLEAN) advance();
    check_value("err_o", err_o, '0);

    step_window(1, 1'b0);
    check_value("err_o.step_multi", err_o.step_multi, 1'b0);
    step_window(2, 1'b0);
    check_value("err_o.step_multi", err_o.step_multi, 1'b1);
    apply_reset();
    step_window(1, 1'b1);
    check_value("err_o.step_irq", err_o.step_irq, 1'b1);

    // Random stepping is judged by the model alone
    apply_reset();
    repeat (N_STEP_RND) begin
      advance();
      step_i     = ($random(seed) & 3) == 0;
      wb_valid_i = ($random(seed) & 1) != 0;
      irq_ack_i  = ($random(seed) & 7) == 0;
      if (($random(seed) & 7) == 0) debug_mode_i = ~debug_mode_i;
    end

    apply_reset();
    trap_round(-1, 1'b1);
    check_value("err_o.mepc", err_o.mepc, '0);
    trap_round(-1, 1'b0);
    check_value("err_o.mepc", err_o.mepc, '0);
    apply_reset();
    bad_idx = {$random(seed)} % 6;
    trap_round(bad_idx, 1'b1);
    check_value("err_o.mepc", err_o.mepc, 64'd1 << bad_idx);

    // Sparse sideband faults on both buses
    apply_reset();
    inject_faults = 1'b1;
    repeat (N_BUS) advance();
    inject_faults = 1'b0;
    repeat (2) advance();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
core_mon_pkg.sv
bus_integrity_check.sv
step_fsm.sv
retire_counter.sv
trap_pc_tracker.sv
core_mon_top.sv
tb_core_mon.sv
